// ==== hw/chan_pkg.sv ====
package chan_pkg;

  // data path widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int CMD_W  = 32;

  // plain word types
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CMD_W-1:0]  cmd_t;

  // channel command code, top nibble of the command word
  localparam logic [3:0] CMD_CHN = 4'h6;

  // thread header sits below both thread bases
  localparam addr_t HEADER_SPACE = 32'd16;

  // codes carried on the cpu message bus
  typedef enum logic [7:0] {
    // idle bus value
    MSG_NONE        = 8'h00,
    // channel write request
    MSG_CHAN_SET,
    // channel read request
    MSG_CHAN_GET,
    // thread address follows every request
    MSG_THREAD_ADDR,
    // thread parked by the peer
    MSG_OP_ACCEPTED,
    // nothing ready yet, retry next time
    MSG_NO_RESULTS,
    // read completed, data on the bus
    MSG_RES_RD,
    // write completed
    MSG_RES_WR
  } cpu_msg_e;

  // transfer sequencer states
  typedef enum logic [1:0] {
    // waiting for a start strobe
    XF_IDLE,
    // sending the thread address
    XF_ADDR,
    // waiting for the reply
    XF_WAIT,
    // one cycle to finish after no-results
    XF_RETRY
  } xfer_state_e;

endpackage

// ==== hw/cpu_msg_port.sv ====
`timescale 1ns/1ps

module cpu_msg_port
  import chan_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // message from the sequencer
  input  logic     send_i,
  input  cpu_msg_e code_i,
  input  addr_t    addr_i,
  input  data_t    data_i,
  input  logic     chan_active_i,

  // cpu message bus
  output logic     cpu_msg_pulse_o,
  output cpu_msg_e cpu_msg_o,
  output addr_t    addr_o,
  output data_t    data_o,
  output logic     chan_msg_strb_o
);

  cpu_msg_e code_r;
  addr_t    addr_r;
  data_t    data_r;

  // pulse and channel strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      cpu_msg_pulse_o <= 1'b0;
      chan_msg_strb_o <= 1'b0;
    end else begin
      // one cycle per send
      cpu_msg_pulse_o <= send_i;
      chan_msg_strb_o <= chan_active_i;
    end
  end

  // message contents
  always_ff @(posedge clk) begin
    if (send_i) begin
      code_r <= code_i;
      addr_r <= addr_i;
      data_r <= data_i;
    end
  end

  // bus is zero outside the pulse
  assign cpu_msg_o = cpu_msg_pulse_o ? code_r : MSG_NONE;
  assign addr_o    = cpu_msg_pulse_o ? addr_r : '0;
  assign data_o    = cpu_msg_pulse_o ? data_r : '0;

endmodule

// ==== hw/chan_xfer_fsm.sv ====
`timescale 1ns/1ps

module chan_xfer_fsm
  import chan_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // launch from the dispatcher
  input  logic     start_i,
  input  logic     is_get_i,
  input  addr_t    chan_i,
  input  data_t    value_i,
  input  addr_t    thread_addr_i,
  input  addr_t    thread_data_i,

  // reply from the cpu bus
  input  logic     cpu_msg_valid_i,
  input  cpu_msg_e cpu_msg_i,
  input  data_t    data_i,

  // outgoing message
  output logic     send_o,
  output cpu_msg_e send_code_o,
  output addr_t    send_addr_o,
  output data_t    send_data_o,
  output logic     chan_active_o,

  // report back to the dispatcher
  output logic     done_o,
  output data_t    data_o,
  output logic     escape_o,
  output logic     retry_o
);

  xfer_state_e state;
  xfer_state_e state_nxt;

  logic reply;
  logic res_ok;

  // replies count only while waiting
  assign reply = (state == XF_WAIT) && cpu_msg_valid_i;

  // the result code must match the direction
  assign res_ok = reply && ((is_get_i && cpu_msg_i == MSG_RES_RD) ||
                            (!is_get_i && cpu_msg_i == MSG_RES_WR));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= XF_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      XF_IDLE: begin
        if (start_i) begin
          state_nxt = XF_ADDR;
        end
      end
      XF_ADDR: begin
        state_nxt = XF_WAIT;
      end
      XF_WAIT: begin
        if (res_ok) begin
          state_nxt = XF_IDLE;
        end else if (reply && cpu_msg_i == MSG_NO_RESULTS) begin
          state_nxt = XF_RETRY;
        end else if (reply && cpu_msg_i == MSG_OP_ACCEPTED) begin
          state_nxt = XF_IDLE;
        end
      end
      XF_RETRY: begin
        state_nxt = XF_IDLE;
      end
      default: begin
        state_nxt = XF_IDLE;
      end
    endcase
  end

  // outgoing messages, request then thread address
  always_comb begin
    send_o      = 1'b0;
    send_code_o = MSG_NONE;
    send_addr_o = '0;
    send_data_o = '0;
    if (state == XF_IDLE && start_i) begin
      send_o      = 1'b1;
      send_code_o = is_get_i ? MSG_CHAN_GET : MSG_CHAN_SET;
      send_addr_o = chan_i;
      // a get carries no payload
      send_data_o = is_get_i ? '0 : value_i;
    end else if (state == XF_ADDR) begin
      send_o      = 1'b1;
      send_code_o = MSG_THREAD_ADDR;
      // both bases point past the thread header
      send_addr_o = thread_addr_i - HEADER_SPACE;
      send_data_o = data_t'(thread_data_i - HEADER_SPACE);
    end
  end

  // channel strobe covers both outgoing messages
  assign chan_active_o = (state == XF_IDLE && start_i) || (state == XF_ADDR);

  // result, retry end and escape
  always_comb begin
    done_o   = 1'b0;
    data_o   = '0;
    escape_o = 1'b0;
    retry_o  = 1'b0;
    if (res_ok) begin
      done_o = 1'b1;
      // only a read returns data
      data_o = is_get_i ? data_i : '0;
    end
    if (reply && cpu_msg_i == MSG_NO_RESULTS) begin
      retry_o = 1'b1;
    end
    if (reply && cpu_msg_i == MSG_OP_ACCEPTED) begin
      escape_o = 1'b1;
    end
    // retry closes with a zero result
    if (state == XF_RETRY) begin
      done_o = 1'b1;
    end
  end

endmodule

// ==== hw/chan_dispatch.sv ====
`timescale 1ns/1ps

module chan_dispatch
  import chan_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // command strobe from the pipeline
  input  logic  cmd_valid_i,
  input  cmd_t  cmd_i,
  input  data_t src1_i,
  input  data_t src0_i,
  input  addr_t base_addr_i,
  input  addr_t base_addr_data_i,
  input  logic  disp_online_i,

  // sequencer report
  input  logic  xfer_done_i,
  input  data_t xfer_data_i,
  input  logic  xfer_escape_i,
  input  logic  xfer_retry_i,

  // sequencer launch
  output logic  xfer_start_o,
  output logic  xfer_is_get_o,
  output addr_t xfer_chan_o,
  output data_t xfer_value_o,
  output addr_t xfer_thread_addr_o,
  output addr_t xfer_thread_data_o,

  // result and status
  output data_t dst_o,
  output logic  done_o,
  output logic  escape_o,
  output logic  wait_next_o
);

  logic [3:0] cmd_code;
  logic       src1_en;
  logic       src0_en;
  logic       dst_en;
  logic       is_chn;
  logic       is_put;
  logic       is_get;
  logic       is_conv;
  logic       busy;
  logic       accept;
  data_t      conv_sum;

  assign cmd_code = cmd_i[31:28];

  // a field is enabled unless both of its bits are set
  assign src1_en = !(cmd_i[21] & cmd_i[20]);
  assign src0_en = !(cmd_i[23] & cmd_i[22]);
  assign dst_en  = !(cmd_i[25] & cmd_i[24]);

  assign is_chn = (cmd_code == CMD_CHN);

  // flag combinations, ordered {dst, src0, src1}
  assign is_put  = is_chn && ({dst_en, src0_en, src1_en} == 3'b011);
  assign is_get  = is_chn && ({dst_en, src0_en, src1_en} == 3'b110);
  assign is_conv = is_chn && ({dst_en, src0_en, src1_en} == 3'b101);

  // offline or busy strobes are dropped
  assign accept = cmd_valid_i && disp_online_i && !busy;

  // convert adds the thread data base
  assign conv_sum = src1_i + data_t'(base_addr_data_i);

  // control and status
  always_ff @(posedge clk) begin
    if (rst) begin
      busy         <= 1'b0;
      xfer_start_o <= 1'b0;
      done_o       <= 1'b0;
      escape_o     <= 1'b0;
      wait_next_o  <= 1'b0;
      dst_o        <= '0;
    end else begin
      // single-cycle pulses by default
      xfer_start_o <= 1'b0;
      done_o       <= 1'b0;
      escape_o     <= 1'b0;

      if (accept) begin
        // a new command drops any pending retry
        wait_next_o <= 1'b0;
        if (is_put || is_get) begin
          busy         <= 1'b1;
          xfer_start_o <= 1'b1;
        end else begin
          // convert or rejection finishes here
          done_o <= 1'b1;
          dst_o  <= is_conv ? conv_sum : '0;
        end
      end

      // transfer finished, result or retry end
      if (xfer_done_i) begin
        busy   <= 1'b0;
        done_o <= 1'b1;
        dst_o  <= xfer_data_i;
      end

      // retry flag holds until the next command
      if (xfer_retry_i) begin
        wait_next_o <= 1'b1;
      end

      // thread parked, no done follows
      if (xfer_escape_i) begin
        busy     <= 1'b0;
        escape_o <= 1'b1;
      end
    end
  end

  // operands captured for the sequencer, held while busy
  always_ff @(posedge clk) begin
    if (accept) begin
      xfer_is_get_o      <= is_get;
      xfer_chan_o        <= addr_t'(src0_i);
      xfer_value_o       <= src1_i;
      xfer_thread_addr_o <= base_addr_i;
      xfer_thread_data_o <= base_addr_data_i;
    end
  end

endmodule

// ==== hw/chan_ctlr.sv ====
`timescale 1ns/1ps

module chan_ctlr
  import chan_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // channel command
  input  logic     cmd_valid_i,
  input  cmd_t     cmd_i,
  input  data_t    src1_i,
  input  data_t    src0_i,
  input  addr_t    base_addr_i,
  input  addr_t    base_addr_data_i,
  input  logic     disp_online_i,

  // reply from the cpu bus
  input  logic     cpu_msg_valid_i,
  input  cpu_msg_e cpu_msg_i,
  // reply address is not checked by the sequencer
  input  addr_t    addr_i,
  input  data_t    data_i,

  // result and status
  output data_t    dst_o,
  output logic     done_o,
  output logic     escape_o,
  output logic     wait_next_o,

  // outgoing cpu message bus
  output logic     cpu_msg_pulse_o,
  output cpu_msg_e cpu_msg_o,
  output addr_t    addr_o,
  output data_t    data_o,
  output logic     chan_msg_strb_o
);

  // dispatch to sequencer
  logic     xfer_start;
  logic     xfer_is_get;
  addr_t    xfer_chan;
  data_t    xfer_value;
  addr_t    xfer_thread_addr;
  addr_t    xfer_thread_data;

  // sequencer to dispatch
  logic     xfer_done;
  data_t    xfer_data;
  logic     xfer_escape;
  logic     xfer_retry;

  // sequencer to message port
  logic     send;
  cpu_msg_e send_code;
  addr_t    send_addr;
  data_t    send_data;
  logic     chan_active;

  chan_dispatch i_dispatch (
    .clk                (clk),
    .rst                (rst),
    .cmd_valid_i        (cmd_valid_i),
    .cmd_i              (cmd_i),
    .src1_i             (src1_i),
    .src0_i             (src0_i),
    .base_addr_i        (base_addr_i),
    .base_addr_data_i   (base_addr_data_i),
    .disp_online_i      (disp_online_i),
    .xfer_done_i        (xfer_done),
    .xfer_data_i        (xfer_data),
    .xfer_escape_i      (xfer_escape),
    .xfer_retry_i       (xfer_retry),
    .xfer_start_o       (xfer_start),
    .xfer_is_get_o      (xfer_is_get),
    .xfer_chan_o        (xfer_chan),
    .xfer_value_o       (xfer_value),
    .xfer_thread_addr_o (xfer_thread_addr),
    .xfer_thread_data_o (xfer_thread_data),
    .dst_o              (dst_o),
    .done_o             (done_o),
    .escape_o           (escape_o),
    .wait_next_o        (wait_next_o)
  );

  chan_xfer_fsm i_xfer (
    .clk             (clk),
    .rst             (rst),
    .start_i         (xfer_start),
    .is_get_i        (xfer_is_get),
    .chan_i          (xfer_chan),
    .value_i         (xfer_value),
    .thread_addr_i   (xfer_thread_addr),
    .thread_data_i   (xfer_thread_data),
    .cpu_msg_valid_i (cpu_msg_valid_i),
    .cpu_msg_i       (cpu_msg_i),
    .data_i          (data_i),
    .send_o          (send),
    .send_code_o     (send_code),
    .send_addr_o     (send_addr),
    .send_data_o     (send_data),
    .chan_active_o   (chan_active),
    .done_o          (xfer_done),
    .data_o          (xfer_data),
    .escape_o        (xfer_escape),
    .retry_o         (xfer_retry)
  );

  cpu_msg_port i_msg_port (
    .clk             (clk),
    .rst             (rst),
    .send_i          (send),
    .code_i          (send_code),
    .addr_i          (send_addr),
    .data_i          (send_data),
    .chan_active_i   (chan_active),
    .cpu_msg_pulse_o (cpu_msg_pulse_o),
    .cpu_msg_o       (cpu_msg_o),
    .addr_o          (addr_o),
    .data_o          (data_o),
    .chan_msg_strb_o (chan_msg_strb_o)
  );

endmodule

// ==== sim/chan_ctlr_assertions.sv ====
`timescale 1ns/1ps

module chan_ctlr_assertions
  import chan_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     cmd_valid_i,
  input cmd_t     cmd_i,
  input logic     online_i,
  input logic     done_i,
  input logic     escape_i,
  input logic     pulse_i,
  input cpu_msg_e msg_i,
  input addr_t    addr_i,
  input data_t    data_i
);

  logic conv_cmd;

  // failed assertions so far
  int   fail_count = 0;

  // convert has the chn code with source-0 off and the other two fields on
  assign conv_cmd = (cmd_i[31:28] == CMD_CHN) && (cmd_i[23:22] == 2'b11) &&
                    (cmd_i[21:20] != 2'b11) && (cmd_i[25:24] != 2'b11);

  // bus idles at zero between pulses
  a_bus_zero: assert property (@(posedge clk) disable iff (rst)
    !pulse_i |-> (msg_i == MSG_NONE && addr_i == '0 && data_i == '0))
    else begin
      fail_count++;
      $error("message bus not zero outside a pulse");
    end

  // a command ends one way only
  a_done_escape: assert property (@(posedge clk) disable iff (rst) !(done_i && escape_i))
    else begin
      fail_count++;
      $error("done and escape high in the same cycle");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done held for more than one cycle");
    end

  // convert completes in the cycle after its strobe
  a_conv_done: assert property (@(posedge clk) disable iff (rst)
    cmd_valid_i && online_i && conv_cmd |=> done_i)
    else begin
      fail_count++;
      $error("convert did not complete one cycle after the strobe");
    end

endmodule

bind chan_ctlr chan_ctlr_assertions i_assertions (
  .clk         (clk),
  .rst         (rst),
  .cmd_valid_i (cmd_valid_i),
  .cmd_i       (cmd_i),
  .online_i    (disp_online_i),
  .done_i      (done_o),
  .escape_i    (escape_o),
  .pulse_i     (cpu_msg_pulse_o),
  .msg_i       (cpu_msg_o),
  .addr_i      (addr_o),
  .data_i      (data_o)
);

// ==== sim/tb_chan_ctlr.sv ====
`timescale 1ns/1ps

module tb_chan_ctlr
  import chan_pkg::*;
();

  localparam int N_TESTS     = 50;
  localparam int CLK_PERIOD  = 20;
  localparam int TEST_CYCLES = 20;
  localparam int WATCHDOG_NS = (N_TESTS * TEST_CYCLES + 100) * CLK_PERIOD;
  // command kinds
  localparam int K_REJ  = 0;
  localparam int K_CONV = 1;
  localparam int K_PUT  = 2;
  localparam int K_GET  = 3;

  logic     clk;
  logic     rst;
  logic     cmd_valid;
  cmd_t     cmd;
  data_t    src1;
  data_t    src0;
  addr_t    base_addr;
  addr_t    base_addr_data;
  logic     disp_online;
  logic     rep_valid;
  cpu_msg_e rep_msg;
  addr_t    rep_addr;
  data_t    rep_bus_data;
  data_t    dst;
  logic     done;
  logic     escape;
  logic     wait_next;
  logic     pulse;
  cpu_msg_e msg_out;
  addr_t    addr_out;
  data_t    data_out;
  logic     chan_strb;

  // current test and its expected outcome
  string    cur_name;
  int       cur_kind;
  cmd_t     cur_cmd;
  logic     exp_done;
  logic     exp_esc;
  logic     exp_wait;
  data_t    exp_dst;
  cpu_msg_e rep_code;
  data_t    rep_data;
  int       rep_delay;
  bit       rep_noise;
  bit       active;
  bit       finished;
  int       cyc;
  int       strobe_cyc;
  int       reply_cyc;
  int       pulse_cnt;
  int       errors;
  int       passes;
  int       fails;

  chan_ctlr i_dut (
    .clk (clk), .rst (rst),
    .cmd_valid_i (cmd_valid), .cmd_i (cmd), .src1_i (src1), .src0_i (src0),
    .base_addr_i (base_addr), .base_addr_data_i (base_addr_data),
    .disp_online_i (disp_online),
    .cpu_msg_valid_i (rep_valid), .cpu_msg_i (rep_msg), .addr_i (rep_addr),
    .data_i (rep_bus_data),
    .dst_o (dst), .done_o (done), .escape_o (escape), .wait_next_o (wait_next),
    .cpu_msg_pulse_o (pulse), .cpu_msg_o (msg_out), .addr_o (addr_out),
    .data_o (data_out), .chan_msg_strb_o (chan_strb)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // cycle count read on the falling edge
  always @(posedge clk) cyc <= cyc + 1;

  // checker errors plus failed bound assertions
  function automatic int error_total();
    return errors + i_dut.i_assertions.fail_count;
  endfunction

  // kind from the code nibble and the three field pairs
  function automatic int cmd_kind(input cmd_t c);
    logic s1_off;
    logic s0_off;
    logic d_off;
    s1_off = (c[21:20] == 2'b11);
    s0_off = (c[23:22] == 2'b11);
    d_off  = (c[25:24] == 2'b11);
    if (c[31:28] != CMD_CHN) return K_REJ;
    if (d_off && !s0_off && !s1_off) return K_PUT;
    if (s1_off && !s0_off && !d_off) return K_GET;
    if (s0_off && !s1_off && !d_off) return K_CONV;
    return K_REJ;
  endfunction

  function automatic void ref_result(input cmd_t c, input data_t s1, input addr_t bd,
                                     input cpu_msg_e rep, input data_t rd,
                                     output logic r_done, output data_t r_dst,
                                     output logic r_esc, output logic r_wait);
    int k;
    k = cmd_kind(c);
    r_done = 1'b1;
    r_dst  = '0;
    r_esc  = 1'b0;
    r_wait = 1'b0;
    if (k == K_CONV) begin
      r_dst = s1 + bd;
    end else if (k == K_PUT || k == K_GET) begin
      // only a read result carries data back
      if (rep == MSG_RES_RD && k == K_GET) r_dst = rd;
      if (rep == MSG_NO_RESULTS) r_wait = 1'b1;
      if (rep == MSG_OP_ACCEPTED) begin
        r_done = 1'b0;
        r_esc  = 1'b1;
      end
    end
  endfunction

  // an enabled field is any pair but 11
  function automatic logic [1:0] field_on();
    return 2'($urandom_range(0, 2));
  endfunction

  function automatic cmd_t make_cmd(input int k);
    cmd_t       c;
    logic [3:0] code;
    c = $urandom;
    c[31:28] = CMD_CHN;
    c[25:24] = (k == K_PUT) ? 2'b11 : field_on();
    c[23:22] = (k == K_CONV) ? 2'b11 : field_on();
    c[21:20] = (k == K_GET) ? 2'b11 : field_on();
    if (k == K_REJ) begin
      if ($urandom_range(0, 1) == 0) begin
        // any code but chn
        code = 4'($urandom_range(0, 14));
        if (code >= CMD_CHN) code = code + 4'd1;
        c[31:28] = code;
      end else if ($urandom_range(0, 1) == 0) begin
        c[25:20] = 6'b111111;
      end
      // otherwise all three stay enabled as in the dropped query form
    end
    return c;
  endfunction

  function automatic cpu_msg_e pick_reply(input int k);
    int r;
    r = $urandom_range(0, 3);
    if (r == 2) return MSG_NO_RESULTS;
    if (r == 3) return MSG_OP_ACCEPTED;
    return (k == K_GET) ? MSG_RES_RD : MSG_RES_WR;
  endfunction

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("Error %s %s: expected %h, actual %h", cur_name, what, exp, act);
  endtask

  task automatic close_test(input string name, input int err0);
    if (error_total() == err0) begin
      passes++;
      $display("test %s: ok", name);
    end else begin
      fails++;
      $display("test %s: fail, %0d errors", name, error_total() - err0);
    end
  endtask

  task automatic run_test(input string name, input int k, input cpu_msg_e rep);
    int err0;
    int waited;
    err0 = error_total();
    cur_name  = name;
    cur_kind  = k;
    cur_cmd   = make_cmd(k);
    rep_code  = rep;
    rep_data  = $urandom;
    rep_delay = $urandom_range(0, 8);
    rep_noise = ($urandom_range(0, 3) == 0);
    pulse_cnt = 0;
    finished  = 1'b0;
    @(negedge clk);
    cmd_valid      = 1'b1;
    cmd            = cur_cmd;
    src1           = $urandom;
    src0           = $urandom;
    base_addr      = $urandom;
    base_addr_data = $urandom;
    ref_result(cur_cmd, src1, base_addr_data, rep, rep_data,
               exp_done, exp_dst, exp_esc, exp_wait);
    strobe_cyc = cyc;
    active     = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    waited = 0;
    while (!finished && waited < 30) begin
      @(negedge clk);
      waited++;
    end
    if (!finished) begin
      errors++;
      active = 1'b0;
      $display("%s: neither done nor escape within 30 cycles of the command", name);
    end
    if ((k == K_PUT || k == K_GET) && pulse_cnt != 2) value_error("pulse count", 2, pulse_cnt);
    // watch for a done trailing an escape
    if (exp_esc) repeat (4) @(negedge clk);
    else @(negedge clk);
    close_test(name, err0);
  endtask

  // the strobe must vanish while the dispatcher is offline
  task automatic offline_test(input string name);
    int err0;
    err0 = error_total();
    cur_name = name;
    active   = 1'b0;
    @(negedge clk);
    disp_online = 1'b0;
    cmd_valid   = 1'b1;
    cmd         = make_cmd(K_PUT);
    @(negedge clk);
    cmd_valid = 1'b0;
    repeat (10) @(negedge clk);
    disp_online = 1'b1;
    close_test(name, err0);
  endtask

  // cpu responder answers the thread address after a random delay
  always @(negedge clk) begin
    if (!rst && pulse && msg_out == MSG_THREAD_ADDR) begin
      repeat (rep_delay) @(negedge clk);
      if (rep_noise) begin
        // wrong direction result to be ignored
        rep_valid    = 1'b1;
        rep_msg      = (cur_kind == K_GET) ? MSG_RES_WR : MSG_RES_RD;
        rep_bus_data = ~rep_data;
        @(negedge clk);
      end
      rep_valid    = 1'b1;
      rep_msg      = rep_code;
      rep_addr     = src0;
      rep_bus_data = rep_data;
      reply_cyc    = cyc;
      @(negedge clk);
      rep_valid    = 1'b0;
      rep_msg      = MSG_NONE;
      rep_addr     = '0;
      rep_bus_data = '0;
    end
  end

  // comparer samples the registered outputs on the falling edge
  always @(negedge clk) begin : compare
    int exp_cyc;
    if (!rst && pulse) begin
      if (!active || (cur_kind != K_PUT && cur_kind != K_GET)) begin
        errors++;
        $display("%s: message pulse with no transfer in flight", cur_name);
      end else begin
        pulse_cnt++;
        if (!chan_strb) begin
          errors++;
          $display("%s: channel strobe low during a message pulse", cur_name);
        end
        if (pulse_cnt == 1) begin
          if (cyc != strobe_cyc + 2) value_error("request cycle", strobe_cyc + 2, cyc);
          if (cur_kind == K_PUT && msg_out != MSG_CHAN_SET)
            value_error("request code", MSG_CHAN_SET, msg_out);
          if (cur_kind == K_GET && msg_out != MSG_CHAN_GET)
            value_error("request code", MSG_CHAN_GET, msg_out);
          if (addr_out != src0) value_error("channel id", src0, addr_out);
          if (cur_kind == K_PUT && data_out != src1) value_error("put value", src1, data_out);
        end else if (pulse_cnt == 2) begin
          if (cyc != strobe_cyc + 3) value_error("thread cycle", strobe_cyc + 3, cyc);
          if (msg_out != MSG_THREAD_ADDR) value_error("thread code", MSG_THREAD_ADDR, msg_out);
          if (addr_out != base_addr - HEADER_SPACE)
            value_error("thread addr", base_addr - HEADER_SPACE, addr_out);
          if (data_out != base_addr_data - HEADER_SPACE)
            value_error("thread data", base_addr_data - HEADER_SPACE, data_out);
        end else begin
          errors++;
          $display("%s: more than two message pulses", cur_name);
        end
      end
    end
    if (!rst && (done || escape)) begin
      if (!active) begin
        errors++;
        $display("%s: done or escape with no command in flight", cur_name);
      end else begin
        if (cur_kind == K_PUT || cur_kind == K_GET) begin
          exp_cyc = (rep_code == MSG_NO_RESULTS) ? reply_cyc + 2 : reply_cyc + 1;
        end else begin
          exp_cyc = strobe_cyc + 1;
        end
        if (cyc != exp_cyc) value_error("end cycle", exp_cyc, cyc);
        if (done != exp_done) value_error("done", exp_done, done);
        if (escape != exp_esc) value_error("escape", exp_esc, escape);
        if (done && dst != exp_dst) value_error("dst", exp_dst, dst);
        if (wait_next != exp_wait) value_error("wait_next", exp_wait, wait_next);
        active   = 1'b0;
        finished = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, run hung after %0d of %0d tests", passes + fails, N_TESTS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int k;
    void'($urandom(92));
    rst            = 1'b1;
    cyc            = 0;
    errors         = 0;
    passes         = 0;
    fails          = 0;
    active         = 1'b0;
    cur_name       = "reset";
    cmd_valid      = 1'b0;
    cmd            = '0;
    src1           = '0;
    src0           = '0;
    base_addr      = '0;
    base_addr_data = '0;
    disp_online    = 1'b1;
    rep_valid      = 1'b0;
    rep_msg        = MSG_NONE;
    rep_addr       = '0;
    rep_bus_data   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // directed cases first
    run_test("convert", K_CONV, MSG_NONE);
    run_test("put_result", K_PUT, MSG_RES_WR);
    run_test("get_result", K_GET, MSG_RES_RD);
    run_test("put_retry", K_PUT, MSG_NO_RESULTS);
    run_test("get_after_retry", K_GET, MSG_RES_RD);
    run_test("get_escape", K_GET, MSG_OP_ACCEPTED);
    run_test("put_after_escape", K_PUT, MSG_RES_WR);
    run_test("reject", K_REJ, MSG_NONE);
    offline_test("offline");
    for (int i = 9; i < N_TESTS; i++) begin
      k = $urandom_range(0, 3);
      run_test($sformatf("rand_%0d", i), k, pick_reply(k));
    end
    $display("%0d tests, %0d ok, %0d failing, %0d errors",
             passes + fails, passes, fails, error_total());
    if (error_total() == 0 && fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hw/chan_pkg.sv
hw/cpu_msg_port.sv
hw/chan_xfer_fsm.sv
hw/chan_dispatch.sv
hw/chan_ctlr.sv
sim/chan_ctlr_assertions.sv
sim/tb_chan_ctlr.sv
